// File: design/vgc_pkg.sv
package vgc_pkg;

    // Plain vector types with a meaning of their own
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  color8_t;
    typedef logic [3:0]  pal_idx_t;
    typedef logic [22:0] vid_addr_t;

    // Palette entry, 4 bits per component
    typedef struct packed {
        nibble_t r;
        nibble_t g;
        nibble_t b;
    } rgb12_t;

    // Scanline control byte as stored in memory
    typedef struct packed {
        logic       mode640;
        logic       irq_en;
        logic       fill;
        logic       rsvd;
        logic [3:0] pal_sel;
    } scb_t;

    // What the byte on video_data currently is
    typedef enum logic [1:0] {
        FETCH_NONE,
        FETCH_SCB,
        FETCH_PAL,
        FETCH_PIX
    } fetch_kind_e;

    typedef struct packed {
        fetch_kind_e kind;
        logic [7:0]  idx;
    } fetch_tag_t;

    // Visible window
    localparam int unsigned ACTIVE_H_START = 32;
    localparam int unsigned ACTIVE_H_END   = 671;
    localparam int unsigned ACTIVE_V_START = 16;
    localparam int unsigned ACTIVE_V_END   = 207;
    localparam int unsigned VBL_LINE       = 208;
    // Last line whose SCB may raise the scanline interrupt
    localparam int unsigned SCANIRQ_V_LAST = 205;

    // Fetch schedule in H ticks
    localparam int unsigned SCB_FETCH_H  = 908;
    localparam int unsigned PAL_FETCH_H  = 0;
    localparam int unsigned PAL_BYTES    = 32;
    localparam int unsigned PIX_FETCH_H  = 32;
    localparam int unsigned PIX_BYTES    = 160;
    localparam int unsigned PIX_PER_BYTE = 4;

    // Column at H reaches R/G/B after tick H + PIX_LATENCY
    localparam int unsigned PIX_LATENCY = 4;

    // SHR memory map, linear layout only
    localparam vid_addr_t   SCB_BASE    = 23'h19D00;
    localparam vid_addr_t   PAL_BASE    = 23'h19E00;
    localparam int unsigned PAL_STRIDE  = 32;
    localparam vid_addr_t   PIX_BASE    = 23'h12000;
    localparam int unsigned LINE_STRIDE = 160;

    // Standard IIgs colours used for the border
    localparam rgb12_t BORDER_PALETTE [16] = '{
        12'h000, 12'hd03, 12'h009, 12'hd2d,
        12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98,
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

endpackage

// File: design/shr_fetch.sv
`timescale 1ns/1ps

module shr_fetch (
    input  logic                 clk_vid,
    input  logic                 rst_n,
    input  logic                 ce_pix,
    input  logic [9:0]           h,
    input  logic [8:0]           v,
    input  logic                 shr_enable,
    input  logic [7:0]           video_data,
    output vgc_pkg::vid_addr_t   video_addr,
    output vgc_pkg::fetch_tag_t  tag,
    output vgc_pkg::scb_t        scb,
    output logic                 scb_load
);
    import vgc_pkg::*;

    // Offsets of H inside the palette and pixel runs
    logic [9:0] pal_off;
    logic [9:0] pix_off;
    logic       pal_run;
    logic       pix_run;
    logic       scb_addr_tick;
    logic       scb_tag_tick;
    scb_t       scb_in;

    assign pal_off = h - 10'(PAL_FETCH_H);
    assign pix_off = h - 10'(PIX_FETCH_H);

    // Palette bytes are presented at H = 0..31
    assign pal_run = (h >= PAL_FETCH_H) && (h < PAL_FETCH_H + PAL_BYTES);
    // Pixel bytes are presented at H = 32..671, four ticks each
    assign pix_run = (h >= PIX_FETCH_H) && (h < PIX_FETCH_H + PIX_BYTES * PIX_PER_BYTE);

    // Address goes out one tick early so it is held during SCB_FETCH_H
    assign scb_addr_tick = (h == SCB_FETCH_H - 1);
    assign scb_tag_tick  = (h == SCB_FETCH_H);

    // Incoming byte viewed as an SCB
    assign scb_in = scb_t'(video_data);

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            video_addr <= '0;
            tag        <= '{kind: FETCH_NONE, idx: '0};
            scb        <= '0;
            scb_load   <= 1'b0;
        end else if (ce_pix) begin
            // Pulse while the freshly captured SCB is valid
            scb_load <= (tag.kind == FETCH_SCB);
            tag      <= '{kind: FETCH_NONE, idx: '0};

            if (shr_enable) begin
                // Tags trail the address by one tick, in step with video_data
                if (scb_tag_tick) begin
                    tag <= '{kind: FETCH_SCB, idx: '0};
                end else if (pal_run) begin
                    tag <= '{kind: FETCH_PAL, idx: pal_off[7:0]};
                end else if (pix_run && (pix_off[1:0] == 2'd0)) begin
                    tag <= '{kind: FETCH_PIX, idx: pix_off[9:2]};
                end

                if (scb_addr_tick) begin
                    // SCB of the next line
                    video_addr <= vid_addr_t'(SCB_BASE + v + 1 - ACTIVE_V_START);
                end else if (tag.kind == FETCH_SCB) begin
                    scb <= scb_in;
                    // Point at palette byte 0 and hold it until H = 0
                    video_addr <= vid_addr_t'(PAL_BASE + scb_in.pal_sel * PAL_STRIDE);
                end else if (pal_run) begin
                    if (pal_off == 10'(PAL_BYTES - 1)) begin
                        // Palette done, jump to the start of this line's pixels
                        video_addr <= vid_addr_t'(PIX_BASE
                                      + (v - ACTIVE_V_START) * LINE_STRIDE);
                    end else begin
                        video_addr <= video_addr + 1'b1;
                    end
                end else if (pix_run && (pix_off[1:0] == 2'd3)) begin
                    // Next pixel byte every fourth tick
                    video_addr <= video_addr + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/shr_palette.sv
`timescale 1ns/1ps

module shr_palette (
    input  logic                 clk_vid,
    input  logic                 rst_n,
    input  logic                 ce_pix,
    input  vgc_pkg::fetch_tag_t  tag,
    input  logic [7:0]           video_data,
    input  vgc_pkg::pal_idx_t    rd_idx,
    output vgc_pkg::rgb12_t      rd_rgb
);
    import vgc_pkg::*;

    // Sixteen entries of the palette chosen by the line's SCB
    rgb12_t   pal_mem [16];
    pal_idx_t wr_entry;
    logic     wr_odd;
    logic     wr_en;

    // Two bytes per entry, the low address bit picks the half
    assign wr_entry = tag.idx[4:1];
    assign wr_odd   = tag.idx[0];
    assign wr_en    = ce_pix && (tag.kind == FETCH_PAL);

    always_ff @(posedge clk_vid) begin
        if (wr_en) begin
            if (wr_odd) begin
                // Odd byte holds red in the low nibble
                pal_mem[wr_entry].r <= video_data[3:0];
            end else begin
                // Even byte holds green high, blue low
                pal_mem[wr_entry].g <= video_data[7:4];
                pal_mem[wr_entry].b <= video_data[3:0];
            end
        end
    end

    // Registered lookup, one tick behind the index
    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            rd_rgb <= '0;
        end else if (ce_pix) begin
            rd_rgb <= pal_mem[rd_idx];
        end
    end

endmodule

// File: design/shr_pixel_decode.sv
`timescale 1ns/1ps

module shr_pixel_decode (
    input  logic                 clk_vid,
    input  logic                 rst_n,
    input  logic                 ce_pix,
    input  vgc_pkg::fetch_tag_t  tag,
    input  logic [7:0]           video_data,
    input  vgc_pkg::scb_t        scb,
    output vgc_pkg::pal_idx_t    pix_idx,
    output logic                 pix_valid
);
    import vgc_pkg::*;

    logic [7:0] byte_q;
    logic [1:0] phase;
    logic       busy;
    pal_idx_t   last_idx;
    pal_idx_t   idx_640;
    pal_idx_t   idx_320;
    nibble_t    nib_sel;
    logic       use_last;

    // 640 mode cycles through the four palette quarters
    always_comb begin
        case (phase)
            2'd0: idx_640 = {2'b10, byte_q[7:6]};
            2'd1: idx_640 = {2'b11, byte_q[5:4]};
            2'd2: idx_640 = {2'b00, byte_q[3:2]};
            default: idx_640 = {2'b01, byte_q[1:0]};
        endcase
    end

    // 320 mode shows high nibble twice then low nibble twice
    assign nib_sel  = phase[1] ? byte_q[3:0] : byte_q[7:4];
    // Fill mode repeats the last non-zero colour
    assign use_last = scb.fill && (nib_sel == 4'd0);
    assign idx_320  = use_last ? last_idx : nib_sel;

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            phase     <= 2'd0;
            pix_valid <= 1'b0;
            last_idx  <= '0;
        end else if (ce_pix) begin
            pix_valid <= busy;
            if (busy) begin
                phase <= phase + 2'd1;
            end
            // New byte restarts the phase, else stop after four pixels
            if (tag.kind == FETCH_PIX) begin
                busy  <= 1'b1;
                phase <= 2'd0;
            end else if (busy && (phase == 2'd3)) begin
                busy <= 1'b0;
            end
            // First palette byte marks the start of a line
            if ((tag.kind == FETCH_PAL) && (tag.idx == 8'd0)) begin
                last_idx <= '0;
            end else if (busy && !scb.mode640 && (nib_sel != 4'd0)) begin
                last_idx <= nib_sel;
            end
        end
    end

    always_ff @(posedge clk_vid) begin
        if (ce_pix) begin
            if (tag.kind == FETCH_PIX) begin
                byte_q <= video_data;
            end
            pix_idx <= scb.mode640 ? idx_640 : idx_320;
        end
    end

endmodule

// File: design/shr_video_out.sv
`timescale 1ns/1ps

module shr_video_out (
    input  logic               clk_vid,
    input  logic               rst_n,
    input  logic               ce_pix,
    input  logic [9:0]         h,
    input  logic [8:0]         v,
    input  logic               shr_enable,
    input  vgc_pkg::pal_idx_t  border_color,
    input  vgc_pkg::rgb12_t    pix_rgb,
    input  vgc_pkg::scb_t      scb,
    input  logic               scb_load,
    output vgc_pkg::color8_t   r,
    output vgc_pkg::color8_t   g,
    output vgc_pkg::color8_t   b,
    output logic               scanline_irq,
    output logic               vbl_irq
);
    import vgc_pkg::*;

    // Beam position and enable delayed to line up with pix_rgb
    logic [9:0] h_dly  [PIX_LATENCY];
    logic [8:0] v_dly  [PIX_LATENCY];
    logic       en_dly [PIX_LATENCY];
    logic       in_window;
    rgb12_t     border_rgb;
    rgb12_t     out_rgb;

    // Repeat a nibble so 4'hF maps to 8'hFF
    function automatic color8_t widen(input nibble_t n);
        return {n, n};
    endfunction

    always_ff @(posedge clk_vid) begin
        if (ce_pix) begin
            h_dly[0]  <= h;
            v_dly[0]  <= v;
            en_dly[0] <= shr_enable;
            for (int i = 1; i < PIX_LATENCY; i++) begin
                h_dly[i]  <= h_dly[i-1];
                v_dly[i]  <= v_dly[i-1];
                en_dly[i] <= en_dly[i-1];
            end
        end
    end

    assign in_window = en_dly[PIX_LATENCY-1]
                    && (h_dly[PIX_LATENCY-1] >= ACTIVE_H_START)
                    && (h_dly[PIX_LATENCY-1] <= ACTIVE_H_END)
                    && (v_dly[PIX_LATENCY-1] >= ACTIVE_V_START)
                    && (v_dly[PIX_LATENCY-1] <= ACTIVE_V_END);

    assign border_rgb = BORDER_PALETTE[border_color];
    assign out_rgb    = in_window ? pix_rgb : border_rgb;

    always_ff @(posedge clk_vid) begin
        if (!rst_n) begin
            r            <= '0;
            g            <= '0;
            b            <= '0;
            scanline_irq <= 1'b0;
            vbl_irq      <= 1'b0;
        end else if (ce_pix) begin
            r <= widen(out_rgb.r);
            g <= widen(out_rgb.g);
            b <= widen(out_rgb.b);

            // VBL covers the whole first line below the window
            vbl_irq <= (v == VBL_LINE);

            // Scanline request cleared at line start or when SHR is off
            if (!shr_enable || (h == 10'd0)) begin
                scanline_irq <= 1'b0;
            end else if (scb_load && scb.irq_en
                         && (v >= ACTIVE_V_START) && (v <= SCANIRQ_V_LAST)) begin
                scanline_irq <= 1'b1;
            end
        end
    end

endmodule

// File: design/vgc_shr.sv
`timescale 1ns/1ps

module vgc_shr (
    input  logic               clk_vid,
    input  logic               rst_n,
    input  logic               ce_pix,
    input  logic [9:0]         h,
    input  logic [8:0]         v,
    input  logic               shr_enable,
    input  vgc_pkg::pal_idx_t  border_color,
    input  logic [7:0]         video_data,
    output vgc_pkg::vid_addr_t video_addr,
    output vgc_pkg::color8_t   r,
    output vgc_pkg::color8_t   g,
    output vgc_pkg::color8_t   b,
    output logic               scanline_irq,
    output logic               vbl_irq
);
    import vgc_pkg::*;

    fetch_tag_t tag;
    scb_t       scb;
    logic       scb_load;
    pal_idx_t   pix_idx;
    rgb12_t     pix_rgb;

    // Decode stage, schedules every memory read
    shr_fetch shr_fetch_i (
        .clk_vid    (clk_vid),
        .rst_n      (rst_n),
        .ce_pix     (ce_pix),
        .h          (h),
        .v          (v),
        .shr_enable (shr_enable),
        .video_data (video_data),
        .video_addr (video_addr),
        .tag        (tag),
        .scb        (scb),
        .scb_load   (scb_load)
    );

    // Execute stage, palette store and lookup
    shr_palette shr_palette_i (
        .clk_vid    (clk_vid),
        .rst_n      (rst_n),
        .ce_pix     (ce_pix),
        .tag        (tag),
        .video_data (video_data),
        .rd_idx     (pix_idx),
        .rd_rgb     (pix_rgb)
    );

    // Execute stage, pixel bytes to palette indices
    shr_pixel_decode shr_pixel_decode_i (
        .clk_vid    (clk_vid),
        .rst_n      (rst_n),
        .ce_pix     (ce_pix),
        .tag        (tag),
        .video_data (video_data),
        .scb        (scb),
        .pix_idx    (pix_idx),
        .pix_valid  ()
    );

    // Result stage, border mux and interrupts
    shr_video_out shr_video_out_i (
        .clk_vid      (clk_vid),
        .rst_n        (rst_n),
        .ce_pix       (ce_pix),
        .h            (h),
        .v            (v),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .pix_rgb      (pix_rgb),
        .scb          (scb),
        .scb_load     (scb_load),
        .r            (r),
        .g            (g),
        .b            (b),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

endmodule

// File: sim/vgc_shr_ref.svh
`ifndef VGC_SHR_REF_SVH
`define VGC_SHR_REF_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One step per bit taken, newest bit ends up in bit 0
function automatic logic [7:0] rand_byte();
    logic [7:0] val;
    val = '0;
    for (int i = 0; i < 8; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        val = {val[6:0], lfsr_state[0]};
    end
    return val;
endfunction

// Low 16 address bits pick the byte, enough for 10000h..1FFFFh
function automatic logic [7:0] mem_byte(input vid_addr_t addr);
    return mem[addr[15:0]];
endfunction

function automatic void set_byte(input vid_addr_t addr, input logic [7:0] val);
    mem[addr[15:0]] = val;
endfunction

function automatic scb_t scb_of_line(input int line);
    return scb_t'(mem_byte(vid_addr_t'(SCB_BASE + line - 16)));
endfunction

// Pixel p of a 320 mode line, high nibble of each byte first
function automatic nibble_t line_nibble(input int line, input int p);
    logic [7:0] px;
    px = mem_byte(vid_addr_t'(PIX_BASE + (line - 16) * LINE_STRIDE + p / 2));
    if (p % 2 == 0) begin
        return px[7:4];
    end
    return px[3:0];
endfunction

// Expected colour of active column x on line
function automatic rgb12_t ref_column(input int x, input int line);
    scb_t       s;
    logic [7:0] px;
    logic [7:0] lo;
    logic [7:0] hi;
    pal_idx_t   idx;
    nibble_t    nib;
    int         j;
    int         q;
    vid_addr_t  pal_addr;
    s = scb_of_line(line);
    if (s.mode640) begin
        px  = mem_byte(vid_addr_t'(PIX_BASE + (line - 16) * LINE_STRIDE + x / 4));
        j   = x % 4;
        // Leftmost pixel uses entries 8..11, then 12..15, 0..3 and 4..7
        idx = pal_idx_t'(((j + 2) % 4) * 4 + ((px >> (6 - 2 * j)) & 8'h03));
    end else begin
        // Each 320 pixel covers two columns
        q   = x / 2;
        nib = line_nibble(line, q);
        // Fill walks back to the last non-zero pixel, entry 0 if none
        while (s.fill && (nib == 4'd0) && (q > 0)) begin
            q--;
            nib = line_nibble(line, q);
        end
        idx = nib;
    end
    pal_addr = vid_addr_t'(PAL_BASE + s.pal_sel * PAL_STRIDE + 2 * idx);
    lo = mem_byte(pal_addr);
    hi = mem_byte(pal_addr + 1'b1);
    return '{r: hi[3:0], g: lo[7:4], b: lo[3:0]};
endfunction

// Border outside the window or with SHR off
function automatic rgb12_t expected_rgb(input beam_t pos, input pal_idx_t border);
    if (pos.en && (pos.h >= ACTIVE_H_START) && (pos.h <= ACTIVE_H_END)
        && (pos.v >= ACTIVE_V_START) && (pos.v <= ACTIVE_V_END)) begin
        return ref_column(int'(pos.h) - ACTIVE_H_START, int'(pos.v));
    end
    return BORDER_PALETTE[border];
endfunction

task automatic check_color(input string name, input color8_t got, input color8_t exp);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_addr(input string name, input vid_addr_t got, input vid_addr_t exp);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        stop_with_failure();
    end
endtask

`endif

// File: sim/vgc_shr_tb.sv
`timescale 1ns/1ps

module vgc_shr_tb;
    import vgc_pkg::*;

    localparam int H_TOTAL     = 914;
    localparam int V_TOTAL     = 262;
    localparam int CLK_PERIOD  = 100;
    localparam int DRAIN_LIMIT = 20;

    // Beam position and enable of one tick
    typedef struct packed {
        logic [9:0] h;
        logic [8:0] v;
        logic       en;
    } beam_t;

    logic        clk_vid = 1'b0;
    logic        rst_n;
    logic        ce_pix;
    logic [9:0]  h;
    logic [8:0]  v;
    logic        shr_enable;
    pal_idx_t    border_color;
    logic [7:0]  video_data;
    vid_addr_t   video_addr;
    color8_t     r;
    color8_t     g;
    color8_t     b;
    logic        scanline_irq;
    logic        vbl_irq;

    logic [7:0]  mem [65536];
    logic [31:0] lfsr_state;
    vid_addr_t   addr_prev;
    beam_t       beam_hist [PIX_LATENCY + 1];
    rgb12_t      exp_rgb;
    scb_t        next_scb;
    logic        irq_exp;
    int          ticks_driven;
    int          ticks_checked;

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

`include "vgc_shr_ref.svh"

    vgc_shr vgc_shr_i (
        .clk_vid      (clk_vid),
        .rst_n        (rst_n),
        .ce_pix       (ce_pix),
        .h            (h),
        .v            (v),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .r            (r),
        .g            (g),
        .b            (b),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    always #(CLK_PERIOD / 2) clk_vid = ~clk_vid;

    // Memory answers on the next tick with the byte at the address it saw
    always @(negedge clk_vid) begin
        video_data = mem_byte(addr_prev);
        addr_prev  = video_addr;
    end

    // Samples a quarter period after the rising edge
    always begin : compare_outputs
        @(posedge clk_vid);
        #(CLK_PERIOD / 4);
        if (!rst_n) begin
            check_color("r", r, 8'h00);
            check_color("g", g, 8'h00);
            check_color("b", b, 8'h00);
            check_bit("scanline_irq", scanline_irq, 1'b0);
            check_bit("vbl_irq", vbl_irq, 1'b0);
        end else begin
            for (int i = PIX_LATENCY; i > 0; i--) begin
                beam_hist[i] = beam_hist[i - 1];
            end
            beam_hist[0] = '{h: h, v: v, en: shr_enable};
            ticks_checked++;
            // Column that entered PIX_LATENCY ticks ago, nibbles doubled
            if (ticks_checked > PIX_LATENCY) begin
                exp_rgb = expected_rgb(beam_hist[PIX_LATENCY], border_color);
                check_color("r", r, {exp_rgb.r, exp_rgb.r});
                check_color("g", g, {exp_rgb.g, exp_rgb.g});
                check_color("b", b, {exp_rgb.b, exp_rgb.b});
            end
            // Address held through the SCB slot points at the next line's SCB
            if (shr_enable && (h == SCB_FETCH_H - 1)) begin
                check_addr("video_addr", video_addr,
                           vid_addr_t'(SCB_BASE + v + 1 - ACTIVE_V_START));
            end
            // The SCB fetched on this line belongs to the next one
            next_scb = scb_of_line(int'(v) + 1);
            if (!shr_enable || (h == 0)) begin
                irq_exp = 1'b0;
            end else if ((h == SCB_FETCH_H + 2) && next_scb.irq_en
                         && (v >= ACTIVE_V_START) && (v <= SCANIRQ_V_LAST)) begin
                irq_exp = 1'b1;
            end
            check_bit("scanline_irq", scanline_irq, irq_exp);
            check_bit("vbl_irq", vbl_irq, v == VBL_LINE);
        end
    end

    // One full frame, inputs change on the falling edge
    task automatic run_frame(input logic en, input pal_idx_t border);
        for (int line = 0; line < V_TOTAL; line++) begin
            for (int col = 0; col < H_TOTAL; col++) begin
                h            = 10'(col);
                v            = 9'(line);
                shr_enable   = en;
                border_color = border;
                ticks_driven++;
                @(negedge clk_vid);
            end
        end
    endtask

    // Fixed lines 16..18 so 640, 320 and a fill run are all present
    task automatic plant_test_lines();
        set_byte(SCB_BASE + 0, 8'hC1);  // 640 with irq, palette 1
        set_byte(SCB_BASE + 1, 8'h02);
        set_byte(SCB_BASE + 2, 8'h63);  // 320 fill with irq, palette 3
        for (int k = 10; k < 14; k++) begin
            set_byte(PIX_BASE + 2 * LINE_STRIDE + k, 8'h00);
        end
        set_byte(PIX_BASE + 2 * LINE_STRIDE + 14, 8'h50);
    endtask

    initial begin : stimulus
        rst_n         = 1'b0;
        ce_pix        = 1'b1;
        h             = '0;
        v             = '0;
        shr_enable    = 1'b0;
        border_color  = '0;
        video_data    = '0;
        addr_prev     = '0;
        irq_exp       = 1'b0;
        ticks_driven  = 0;
        ticks_checked = 0;
        lfsr_state    = 32'h9917c2d1;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = rand_byte();
        end
        plant_test_lines();
        repeat (2) @(posedge clk_vid);
        @(negedge clk_vid);
        rst_n = 1'b1;
        // Border only, then SHR, then border in another colour
        run_frame(1'b0, 4'd3);
        run_frame(1'b1, 4'd12);
        run_frame(1'b0, 4'd9);
        for (int i = 0; i < DRAIN_LIMIT && ticks_checked < ticks_driven + PIX_LATENCY; i++) begin
            @(negedge clk_vid);
        end
        if (ticks_checked < ticks_driven + PIX_LATENCY) begin
            $display("Timed out waiting for the last outputs to be checked");
            stop_with_failure();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: files.f
+incdir+sim
design/vgc_pkg.sv
design/shr_fetch.sv
design/shr_palette.sv
design/shr_pixel_decode.sv
design/shr_video_out.sv
design/vgc_shr.sv
sim/vgc_shr_tb.sv

// File: Bender.yml
package:
  name: vgc_shr

sources:
  - files:
      - design/vgc_pkg.sv
      - design/shr_fetch.sv
      - design/shr_palette.sv
      - design/shr_pixel_decode.sv
      - design/shr_video_out.sv
      - design/vgc_shr.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/vgc_shr_tb.sv
